//--- source/lsp_defines.svh
`ifndef LSP_DEFINES_SVH
`define LSP_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Frame geometry and operator constants
////////////////////////////////////////////////////////////////////////////

// Elements per frame (LSP order M)
`define LSP_ORDER 10

// MA predictor modes, one distance lane each
`define NUM_MODES 2

// Left shift before the high half is taken
`define TDIST_SHIFT 4

`endif

//--- source/lspPkg.sv
`include "lsp_defines.svh"

package lspPkg;

	////////////////////////////////////////////////////////////////////////////
	// Element and result types
	////////////////////////////////////////////////////////////////////////////

	// Names avoid the buf gate keyword
	typedef struct packed {
		logic signed [15:0] bufVal;
		logic signed [15:0] rbuf;
		logic signed [15:0] wegt;
	} lspElement;

	typedef struct packed {
		lspElement  elem;
		logic [3:0] index;
		logic       last;
	} laneElement;

	typedef struct packed {
		logic signed [31:0] distance;
		logic [1:0]         mode;
	} tdistResult;

	////////////////////////////////////////////////////////////////////////////
	// Saturating basic operators
	////////////////////////////////////////////////////////////////////////////

	function automatic logic signed [15:0] sub16(input logic signed [15:0] a,
		input logic signed [15:0] b);
		logic signed [16:0] diff;
		diff = {a[15], a} - {b[15], b};
		if (diff[16] != diff[15])
			return diff[16] ? 16'sh8000 : 16'sh7fff;
		return diff[15:0];
	endfunction

	// Q15 product, only -1 * -1 can overflow
	function automatic logic signed [15:0] mult16(input logic signed [15:0] a,
		input logic signed [15:0] b);
		logic signed [31:0] prod;
		prod = a * b;
		prod = prod >>> 15;
		if (prod > 32'sd32767)
			return 16'sh7fff;
		if (prod < -32'sd32768)
			return 16'sh8000;
		return prod[15:0];
	endfunction

	function automatic logic signed [31:0] lMult(input logic signed [15:0] a,
		input logic signed [15:0] b);
		logic signed [31:0] prod;
		prod = a * b;
		if (prod == 32'sh40000000)
			return 32'sh7fffffff;
		return {prod[30:0], 1'b0};
	endfunction

	function automatic logic signed [31:0] lShl(input logic signed [31:0] x,
		input logic [4:0] n);
		logic signed [63:0] wide;
		wide = {{32{x[31]}}, x};
		wide = wide <<< n;
		if (wide > 64'sd2147483647)
			return 32'sh7fffffff;
		if (wide < -64'sd2147483648)
			return 32'sh80000000;
		return wide[31:0];
	endfunction

	function automatic logic signed [31:0] lAdd(input logic signed [31:0] a,
		input logic signed [31:0] b);
		logic signed [32:0] sum;
		sum = {a[31], a} + {b[31], b};
		if (sum[32] != sum[31])
			return sum[32] ? 32'sh80000000 : 32'sh7fffffff;
		return sum[31:0];
	endfunction

	function automatic logic signed [15:0] extractHigh(input logic signed [31:0] x);
		return x[31:16];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// fg_sum coefficients per MA mode
	////////////////////////////////////////////////////////////////////////////

	// Rows 2 and 3 cover the four-mode build
	localparam logic signed [15:0] FG_SUM_TABLE [4][`LSP_ORDER] = '{
		'{16'sd7798, 16'sd8447, 16'sd8205, 16'sd8293, 16'sd8126,
		  16'sd8477, 16'sd8447, 16'sd8703, 16'sd9043, 16'sd8604},
		'{16'sd14585, 16'sd18333, 16'sd19772, 16'sd17344, 16'sd16426,
		  16'sd16459, 16'sd15155, 16'sd15220, 16'sd16043, 16'sd15708},
		'{16'sd11020, 16'sd12381, 16'sd12790, 16'sd12107, 16'sd11655,
		  16'sd11842, 16'sd11316, 16'sd11560, 16'sd12218, 16'sd11903},
		'{16'sd20133, 16'sd22410, 16'sd23007, 16'sd21675, 16'sd20981,
		  16'sd20712, 16'sd19854, 16'sd19930, 16'sd20566, 16'sd20247}
	};

	function automatic logic signed [15:0] fgSumCoef(input logic [1:0] mode,
		input logic [3:0] index);
		if (index >= `LSP_ORDER)
			return 16'sd0;
		return FG_SUM_TABLE[mode][index];
	endfunction

endpackage

//--- source/lspFrameFeeder.sv
`timescale 1ns/100ps
`include "lsp_defines.svh"

module lspFrameFeeder
(
	input  logic                clk,
	input  logic                reset,
	input  logic                sampleStrobe,
	input  lspPkg::lspElement   sample,
	output logic                laneStrobe,
	output lspPkg::laneElement  laneIn
);

	localparam logic [3:0] LAST_INDEX = 4'(`LSP_ORDER - 1);

	logic [3:0] count;

	////////////////////////////////////////////////////////////////////////////
	// Element counter
	////////////////////////////////////////////////////////////////////////////

	// Frame boundaries are set here only
	always_ff @(posedge clk)
	begin
		if (reset)
			count <= 4'd0;
		else if (sampleStrobe)
		begin
			if (count == LAST_INDEX)
				count <= 4'd0;
			else
				count <= count + 4'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tagged element register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			laneStrobe <= 1'b0;
		else
			laneStrobe <= sampleStrobe;
	end

	// Payload only moves on a strobe
	always_ff @(posedge clk)
	begin
		if (sampleStrobe)
		begin
			laneIn.elem  <= sample;
			laneIn.index <= count;
			laneIn.last  <= (count == LAST_INDEX);
		end
	end

endmodule

//--- source/tdistLane.sv
`timescale 1ns/100ps
`include "lsp_defines.svh"

module tdistLane
#(
	parameter int MODE = 0
)
(
	input  logic                clk,
	input  logic                reset,
	input  logic                laneStrobe,
	input  lspPkg::laneElement  laneIn,
	output logic                doneStrobe,
	output logic signed [31:0]  laneDistance
);

	localparam logic [4:0] SHIFT = 5'(`TDIST_SHIFT);

	// Stage 1 state
	logic               s1Valid;
	logic               s1First;
	logic               s1Last;
	logic signed [15:0] s1Val;
	logic signed [15:0] s1Wegt;

	// Stage 2 state
	logic               s2Valid;
	logic               s2First;
	logic               s2Last;
	logic signed [15:0] s2Val;
	logic signed [15:0] s2Prod;

	logic signed [31:0] acc;

	////////////////////////////////////////////////////////////////////////////
	// Valid bits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end
		else
		begin
			s1Valid <= laneStrobe;
			s2Valid <= s1Valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 and 2 datapath
	////////////////////////////////////////////////////////////////////////////

	// Scaled difference (buf - rbuf) * fg_sum
	always_ff @(posedge clk)
	begin
		s1Val   <= lspPkg::mult16(lspPkg::sub16(laneIn.elem.bufVal, laneIn.elem.rbuf),
			lspPkg::fgSumCoef(2'(MODE), laneIn.index));
		s1Wegt  <= laneIn.elem.wegt;
		s1First <= (laneIn.index == 4'd0);
		s1Last  <= laneIn.last;
	end

	// Weighted term, high half after the shift
	always_ff @(posedge clk)
	begin
		s2Prod  <= lspPkg::extractHigh(lspPkg::lShl(lspPkg::lMult(s1Wegt, s1Val), SHIFT));
		s2Val   <= s1Val;
		s2First <= s1First;
		s2Last  <= s1Last;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 3 accumulator
	////////////////////////////////////////////////////////////////////////////

	// Element 0 restarts the sum, so no start pulse is needed
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc        <= 32'sd0;
			doneStrobe <= 1'b0;
		end
		else
		begin
			doneStrobe <= s2Valid && s2Last;
			if (s2Valid)
				acc <= lspPkg::lAdd(s2First ? 32'sd0 : acc, lspPkg::lMult(s2Prod, s2Val));
		end
	end

	assign laneDistance = acc;

endmodule

//--- source/tdistSelector.sv
`timescale 1ns/100ps
`include "lsp_defines.svh"

module tdistSelector
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`NUM_MODES-1:0]   doneStrobe,
	input  logic signed [31:0]      laneDistance [`NUM_MODES],
	output logic                    resultStrobe,
	output lspPkg::tdistResult      result
);

	logic               allDone;
	logic signed [31:0] minDist;
	logic [1:0]         minMode;

	// Lanes run in lockstep, so the strobes coincide
	assign allDone = &doneStrobe;

	////////////////////////////////////////////////////////////////////////////
	// Minimum search
	////////////////////////////////////////////////////////////////////////////

	// Strict compare keeps the lowest mode on a tie
	always_comb
	begin
		minDist = laneDistance[0];
		minMode = 2'd0;
		for (int i = 1; i < `NUM_MODES; i++)
		begin
			if (laneDistance[i] < minDist)
			begin
				minDist = laneDistance[i];
				minMode = 2'(i);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Result register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			resultStrobe <= 1'b0;
		else
			resultStrobe <= allDone;
	end

	always_ff @(posedge clk)
	begin
		if (allDone)
		begin
			result.distance <= minDist;
			result.mode     <= minMode;
		end
	end

endmodule

//--- source/lspDistanceTop.sv
`timescale 1ns/100ps
`include "lsp_defines.svh"

module lspDistanceTop
(
	input  logic                clk,
	input  logic                reset,
	input  logic                sampleStrobe,
	input  lspPkg::lspElement   sample,
	output logic                resultStrobe,
	output lspPkg::tdistResult  result
);

	logic                   laneStrobe;
	lspPkg::laneElement     laneIn;
	logic [`NUM_MODES-1:0]  doneStrobe;
	logic signed [31:0]     laneDistance [`NUM_MODES];

	// Counts and tags elements for all lanes
	lspFrameFeeder feeder
	(
		.clk          (clk),
		.reset        (reset),
		.sampleStrobe (sampleStrobe),
		.sample       (sample),
		.laneStrobe   (laneStrobe),
		.laneIn       (laneIn)
	);

	// One distance lane per MA mode
	for (genvar MODE = 0; MODE < `NUM_MODES; MODE++)
	begin : laneGen
		tdistLane #(.MODE(MODE)) lane
		(
			.clk          (clk),
			.reset        (reset),
			.laneStrobe   (laneStrobe),
			.laneIn       (laneIn),
			.doneStrobe   (doneStrobe[MODE]),
			.laneDistance (laneDistance[MODE])
		);
	end

	tdistSelector selector
	(
		.clk          (clk),
		.reset        (reset),
		.doneStrobe   (doneStrobe),
		.laneDistance (laneDistance),
		.resultStrobe (resultStrobe),
		.result       (result)
	);

endmodule

//--- verification/lspDistance_chk.sv
`timescale 1ns/100ps

module lspDistance_chk
(
	input logic clk,
	input logic reset,
	input logic sampleStrobe,
	input logic resultStrobe
);

	// Feeder, three lane stages and the selector register
	localparam int LATENCY = 5;

	////////////////////////////////////////////////////////////////////////////
	// Strobe properties
	////////////////////////////////////////////////////////////////////////////

	resultOnePulse: assert property (@(posedge clk) disable iff (reset)
		resultStrobe |=> !resultStrobe)
		else $error("resultStrobe stayed high for more than one cycle");

	// Output register is cleared one edge into reset
	resultQuietInReset: assert property (@(posedge clk)
		reset |=> !resultStrobe)
		else $error("resultStrobe high while reset is asserted");

	resultLatency: assert property (@(posedge clk) disable iff (reset)
		resultStrobe |-> $past(sampleStrobe, LATENCY))
		else $error("resultStrobe without a sampleStrobe five cycles earlier");

endmodule

//--- verification/lspDistanceTb.sv
`timescale 1ns/100ps
`include "lsp_defines.svh"

module lspDistanceTb;

	localparam int CLK_PERIOD = 4;
	localparam int MAX_GAP = 3;
	localparam int TOTAL_FRAMES = 24;
	// Every strobe may be followed by the longest gap, plus drain and idle time
	localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * `LSP_ORDER * (MAX_GAP + 1) + 300;
	// Cycles allowed for the last result of a test to come out
	localparam int DRAIN_CYCLES = 16;

	localparam int FRAME_RANDOM = 0;
	localparam int FRAME_SAT = 1;
	localparam int FRAME_TIE = 2;

	logic                clk;
	logic                reset;
	logic                sampleStrobe;
	lspPkg::lspElement   sample;
	logic                resultStrobe;
	lspPkg::tdistResult  result;

	int seed = 10878;
	int errorCount = 0;
	int testCount = 0;
	int framesSent = 0;
	int resultCount = 0;
	int strobeCount = 0;
	int cycle = 0;
	int errorsBefore;
	int lastStrobeCycle;

	lspPkg::lspElement   frameBuf [`LSP_ORDER];
	lspPkg::tdistResult  expQ [$];
	lspPkg::tdistResult  gotExpected;
	int                  lastCycleQ [$];

	lspDistanceTop DUT
	(
		.clk          (clk),
		.reset        (reset),
		.sampleStrobe (sampleStrobe),
		.sample       (sample),
		.resultStrobe (resultStrobe),
		.result       (result)
	);

	bind lspDistanceTop lspDistance_chk strobeChk
	(
		.clk          (clk),
		.reset        (reset),
		.sampleStrobe (sampleStrobe),
		.resultStrobe (resultStrobe)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and stimulus
	////////////////////////////////////////////////////////////////////////////

	// Distance per mode over frameBuf with ties to the lowest mode
	function automatic lspPkg::tdistResult modelFrame();
		lspPkg::tdistResult best;
		logic signed [31:0] acc;
		logic signed [15:0] scaled;
		logic signed [15:0] weighted;
		best.distance = 32'sd0;
		best.mode = 2'd0;
		for (int m = 0; m < `NUM_MODES; m++)
		begin
			acc = 32'sd0;
			for (int j = 0; j < `LSP_ORDER; j++)
			begin
				scaled = lspPkg::mult16(lspPkg::sub16(frameBuf[j].bufVal, frameBuf[j].rbuf),
					lspPkg::fgSumCoef(2'(m), 4'(j)));
				weighted = lspPkg::extractHigh(lspPkg::lShl(
					lspPkg::lMult(frameBuf[j].wegt, scaled), 5'(`TDIST_SHIFT)));
				acc = lspPkg::lAdd(acc, lspPkg::lMult(weighted, scaled));
			end
			if (m == 0 || acc < best.distance)
			begin
				best.distance = acc;
				best.mode = 2'(m);
			end
		end
		return best;
	endfunction

	// Builds one frame, queues its expected result, then drives it
	task automatic sendFrame(input int kind, input int maxGap);
		lspPkg::tdistResult expected;
		int gap;
		for (int j = 0; j < `LSP_ORDER; j++)
		begin
			frameBuf[j].bufVal = 16'($random(seed));
			frameBuf[j].rbuf = 16'($random(seed));
			frameBuf[j].wegt = 16'($random(seed));
			if (kind == FRAME_SAT)
				frameBuf[j] = '{16'sh7fff, 16'sh8000, 16'sh7fff};
			else if (kind == FRAME_TIE)
				frameBuf[j].rbuf = frameBuf[j].bufVal;
		end
		// Zero difference means zero in every lane
		if (kind == FRAME_TIE)
			expected = '{distance: 32'sd0, mode: 2'd0};
		else
			expected = modelFrame();
		expQ.push_back(expected);
		framesSent++;
		for (int j = 0; j < `LSP_ORDER; j++)
		begin
			sample = frameBuf[j];
			sampleStrobe = 1'b1;
			@(posedge clk);
			#1;
			sampleStrobe = 1'b0;
			gap = (maxGap == 0) ? 0 : int'({$random(seed)} % (maxGap + 1));
			repeat (gap)
			begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < DRAIN_CYCLES)
		begin
			@(posedge clk);
			waited++;
		end
		repeat (3) @(posedge clk);
		#1;
		if (expQ.size() != 0)
		begin
			$display("Missing result: %0d frames still waiting at %0t ns", expQ.size(), $time);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name);
		testCount++;
		$display("Test %0d %s: %s", testCount, name,
			(errorCount == errorsBefore) ? "passed" : "failed");
		errorsBefore = errorCount;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result monitor
	////////////////////////////////////////////////////////////////////////////

	// Outputs are read at the edge, before the DUT updates them
	always @(posedge clk)
	begin
		if (!reset && sampleStrobe)
		begin
			if (strobeCount == `LSP_ORDER - 1)
			begin
				lastCycleQ.push_back(cycle);
				strobeCount = 0;
			end
			else
				strobeCount++;
		end
		if (!reset && resultStrobe)
		begin
			resultCount++;
			if (expQ.size() == 0 || lastCycleQ.size() == 0)
			begin
				$display("Result strobe at %0t ns with no frame outstanding", $time);
				errorCount++;
			end
			else
			begin
				gotExpected = expQ.pop_front();
				lastStrobeCycle = lastCycleQ.pop_front();
				if (result.distance != gotExpected.distance)
				begin
					$display("ERROR at %0t ns: distance %0d, expected %0d", $time,
						result.distance, gotExpected.distance);
					errorCount++;
				end
				if (result.mode != gotExpected.mode)
				begin
					$display("ERROR at %0t ns: mode %0d, expected %0d", $time,
						result.mode, gotExpected.mode);
					errorCount++;
				end
				if (cycle - lastStrobeCycle != 5)
				begin
					$display("ERROR at %0t ns: result %0d cycles after last strobe, expected 5",
						$time, cycle - lastStrobeCycle);
					errorCount++;
				end
			end
		end
		cycle++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		sampleStrobe = 1'b0;
		sample = '0;
		errorsBefore = 0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (20) @(posedge clk);
		#1;
		if (resultCount != 0)
		begin
			$display("ERROR at %0t ns: %0d results with no input", $time, resultCount);
			errorCount++;
		end
		reportTest("idle after reset");

		repeat (12) sendFrame(FRAME_RANDOM, MAX_GAP);
		waitDrain();
		reportTest("random frames with gaps");

		repeat (6) sendFrame(FRAME_RANDOM, 0);
		waitDrain();
		reportTest("back-to-back frames");

		repeat (3) sendFrame(FRAME_SAT, 0);
		waitDrain();
		reportTest("saturation");

		repeat (3) sendFrame(FRAME_TIE, 1);
		waitDrain();
		reportTest("tie to mode 0");

		if (resultCount != framesSent)
		begin
			$display("ERROR at %0t ns: %0d results, expected %0d", $time, resultCount, framesSent);
			errorCount++;
		end
		if (expQ.size() != 0)
		begin
			$display("ERROR at %0t ns: %0d frames still queued", $time, expQ.size());
			errorCount++;
		end
		reportTest("frame count");

		$display("Tests run: %0d, errors: %0d", testCount, errorCount);
		if (errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- build.f
+incdir+source
source/lspPkg.sv
source/lspFrameFeeder.sv
source/tdistLane.sv
source/tdistSelector.sv
source/lspDistanceTop.sv
verification/lspDistance_chk.sv
verification/lspDistanceTb.sv

//--- Makefile
TOOL       = verilator
TOP        = lspDistanceTb
FILELIST   = build.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Done: errors found
PASS_MSG   = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
